// ==== Makefile ====
TOP = endec_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): sources.f $(wildcard src/*.sv testbench/*.sv)
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Regression failed" sim.log; then exit 1; fi
	@grep -q "Regression passed" sim.log

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f sources.f

clean:
	rm -rf obj_dir sim.log

// ==== sources.f ====
src/viterbi_pkg.sv
src/endec_control.sv
src/conv_encoder.sv
src/acs_unit.sv
src/survivor_memory.sv
src/traceback_unit.sv
src/endec.sv
testbench/endec_checker.sv
testbench/endec_tb.sv

// ==== src/acs_unit.sv ====
module acs_unit (
    input  logic                                   sys_clk,
    input  logic                                   i_rst_n,
    input  logic                                   i_step,
    input  logic                                   i_code_rate,
    input  logic [viterbi_pkg::MAX_RATE-1:0]       i_rx_sym,
    input  logic [viterbi_pkg::EXP_BITS-1:0]       i_exp_sym,
    input  logic                                   i_frame_end,
    input  logic                                   i_bank,
    output logic                                   o_wr_req,
    output logic [viterbi_pkg::SURV_ADDR_BITS-1:0] o_wr_addr,
    output logic [viterbi_pkg::NUM_STATES-1:0]     o_wr_data,
    output logic                                   o_tb_start,
    output logic                                   o_tb_bank
);
    import viterbi_pkg::*;

    logic [METRIC_BITS-1:0] pm_q   [NUM_STATES];
    logic [METRIC_BITS-1:0] pm_sel [NUM_STATES];
    logic [METRIC_BITS-1:0] sum_d  [NUM_STATES][2];
    logic [METRIC_BITS-1:0] sum_q  [NUM_STATES][2];
    logic [NUM_STATES-1:0]  dec;
    logic [MAX_RATE-1:0]    rate_mask;
    logic                   sel_q;
    logic [STEP_BITS-1:0]   step_q;

    assign rate_mask = {i_code_rate, {(MAX_RATE - 1){1'b1}}};

    // ##################################################
    // Add. The predecessor of state s on decision d is {s[1:0], d}.
    // ##################################################
    always_comb begin
        logic [CONSTR_LEN-1:0] win;
        logic [MAX_RATE-1:0]   diff;
        logic [METRIC_BITS:0]  acc;
        for (int s = 0; s < NUM_STATES; s++) begin
            for (int d = 0; d < 2; d++) begin
                win  = {STATE_BITS'(s), 1'(d)};
                diff = (i_rx_sym ^ i_exp_sym[win*MAX_RATE +: MAX_RATE]) & rate_mask;
                acc  = (METRIC_BITS + 1)'(pm_q[win[STATE_BITS-1:0]]);
                for (int j = 0; j < MAX_RATE; j++)
                    acc = acc + diff[j];
                sum_d[s][d] = acc[METRIC_BITS] ? METRIC_MAX : acc[METRIC_BITS-1:0];
            end
        end
    end

    // ##################################################
    // Compare and select. A tie keeps the lower path.
    // ##################################################
    always_comb begin
        for (int s = 0; s < NUM_STATES; s++) begin
            dec[s]    = sum_q[s][1] < sum_q[s][0];
            pm_sel[s] = dec[s] ? sum_q[s][1] : sum_q[s][0];
        end
    end

    assign o_wr_req  = sel_q;
    assign o_wr_addr = {i_bank, step_q};
    assign o_wr_data = dec;

    always_ff @(posedge sys_clk) begin
        if (i_step)
            sum_q <= sum_d;
    end

    always_ff @(posedge sys_clk) begin
        if (!i_rst_n) begin
            sel_q      <= 1'b0;
            step_q     <= '0;
            o_tb_start <= 1'b0;
            o_tb_bank  <= 1'b0;
            for (int s = 0; s < NUM_STATES; s++)
                pm_q[s] <= (s == 0) ? '0 : METRIC_MAX;
        end else begin
            sel_q      <= i_step;
            o_tb_start <= i_frame_end;
            if (i_frame_end) begin                  // Also the cycle of the last write.
                o_tb_bank <= i_bank;
                step_q    <= '0;
                for (int s = 0; s < NUM_STATES; s++)
                    pm_q[s] <= (s == 0) ? '0 : METRIC_MAX;
            end else if (sel_q) begin
                step_q <= step_q + 1'b1;
                pm_q   <= pm_sel;
            end
        end
    end

endmodule

// ==== src/conv_encoder.sv ====
module conv_encoder (
    input  logic                               sys_clk,
    input  logic                               i_rst_n,
    input  logic                               i_enc_start,
    input  logic                               i_enc_bit,
    input  logic                               i_code_rate,
    input  logic [viterbi_pkg::POLY_BITS-1:0]  i_gen_poly,
    output logic [viterbi_pkg::EXP_BITS-1:0]   o_exp_sym,
    output logic [viterbi_pkg::CODE_BITS-1:0]  o_enc_data,
    output logic                               o_enc_done
);
    import viterbi_pkg::*;

    logic [STATE_BITS-1:0] sreg_q;                  // Newest input bit at the MSB.
    logic [STEP_BITS-1:0]  cnt_q;
    logic                  run_q;
    logic [CODE_BITS-1:0]  cw_q;
    logic [CODE_BITS-1:0]  cw_next;
    logic [MAX_RATE-1:0]   sym;

    // One parity bit per generator over the window {input, state}.
    function automatic logic [MAX_RATE-1:0] branch_sym(input logic [CONSTR_LEN-1:0] win,
                                                       input logic [POLY_BITS-1:0] poly);
        logic [MAX_RATE-1:0] res;
        for (int j = 0; j < MAX_RATE; j++)
            res[j] = ^(win & poly[j*CONSTR_LEN +: CONSTR_LEN]);
        return res;
    endfunction

    assign sym = branch_sym({i_enc_bit, sreg_q}, i_gen_poly);

    // The window {to-state, decision} is the same one the encoder sees on that branch.
    for (genvar w = 0; w < 2 * NUM_STATES; w++) begin : g_exp
        assign o_exp_sym[w*MAX_RATE +: MAX_RATE] = branch_sym(CONSTR_LEN'(w), i_gen_poly);
    end

    always_comb begin
        cw_next = cw_q;
        if (i_code_rate)
            cw_next[cnt_q*MAX_RATE +: MAX_RATE] = sym;
        else
            cw_next[cnt_q*(MAX_RATE-1) +: MAX_RATE-1] = sym[MAX_RATE-2:0];
    end

    always_ff @(posedge sys_clk) begin
        if (!i_rst_n) begin
            run_q      <= 1'b0;
            cnt_q      <= '0;
            sreg_q     <= '0;
            o_enc_done <= 1'b0;
            o_enc_data <= '0;
        end else begin
            o_enc_done <= 1'b0;
            if (i_enc_start) begin
                run_q  <= 1'b1;
                cnt_q  <= '0;
                sreg_q <= '0;
            end else if (run_q) begin
                sreg_q <= {i_enc_bit, sreg_q[STATE_BITS-1:1]};
                cnt_q  <= cnt_q + 1'b1;
                if (cnt_q == STEP_BITS'(FRAME_BITS - 1)) begin
                    run_q      <= 1'b0;
                    o_enc_done <= 1'b1;
                    o_enc_data <= cw_next;
                end
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (i_enc_start)
            cw_q <= '0;                             // Rate 1/2 leaves the upper bits at zero.
        else if (run_q)
            cw_q <= cw_next;
    end

endmodule

// ==== src/endec.sv ====
module endec (
    input  logic                               sys_clk,
    input  logic                               i_rst_n,
    input  logic                               i_start,
    input  logic                               i_mode_sel,
    input  logic                               i_code_rate,
    input  logic [viterbi_pkg::POLY_BITS-1:0]  i_gen_poly,
    input  logic [viterbi_pkg::FRAME_BITS-1:0] i_enc_frame,
    input  logic [viterbi_pkg::CODE_BITS-1:0]  i_dec_frame,
    output logic                               o_ready,
    output logic [viterbi_pkg::CODE_BITS-1:0]  o_enc_data,
    output logic                               o_enc_done,
    output logic [viterbi_pkg::FRAME_BITS-1:0] o_dec_data,
    output logic                               o_dec_done
);
    import viterbi_pkg::*;

    logic                      enc_start;
    logic                      enc_bit;
    logic                      step;
    logic [MAX_RATE-1:0]       rx_sym;
    logic                      frame_end;
    logic                      bank;
    logic [EXP_BITS-1:0]       exp_sym;
    logic                      wr_req;
    logic [SURV_ADDR_BITS-1:0] wr_addr;
    logic [NUM_STATES-1:0]     wr_data;
    logic                      wr_grant;
    logic                      tb_start;
    logic                      tb_bank;
    logic                      tb_busy;
    logic                      rd_req;
    logic [SURV_ADDR_BITS-1:0] rd_addr;
    logic                      rd_grant;
    logic [NUM_STATES-1:0]     rd_data;

    endec_control u_ctrl (
        .sys_clk        (sys_clk),
        .i_rst_n        (i_rst_n),
        .i_start        (i_start),
        .i_mode_sel     (i_mode_sel),
        .i_code_rate    (i_code_rate),
        .i_enc_frame    (i_enc_frame),
        .i_dec_frame    (i_dec_frame),
        .i_tb_busy      (tb_busy),
        .i_acs_wr_grant (wr_grant),
        .o_ready        (o_ready),
        .o_enc_start    (enc_start),
        .o_enc_bit      (enc_bit),
        .o_step         (step),
        .o_rx_sym       (rx_sym),
        .o_frame_end    (frame_end),
        .o_bank         (bank)
    );

    conv_encoder u_enc (
        .sys_clk     (sys_clk),
        .i_rst_n     (i_rst_n),
        .i_enc_start (enc_start),
        .i_enc_bit   (enc_bit),
        .i_code_rate (i_code_rate),
        .i_gen_poly  (i_gen_poly),
        .o_exp_sym   (exp_sym),
        .o_enc_data  (o_enc_data),
        .o_enc_done  (o_enc_done)
    );

    // ##################################################
    // Decoder pipeline around the shared survivor store.
    // ##################################################
    acs_unit u_acs (
        .sys_clk     (sys_clk),
        .i_rst_n     (i_rst_n),
        .i_step      (step),
        .i_code_rate (i_code_rate),
        .i_rx_sym    (rx_sym),
        .i_exp_sym   (exp_sym),
        .i_frame_end (frame_end),
        .i_bank      (bank),
        .o_wr_req    (wr_req),
        .o_wr_addr   (wr_addr),
        .o_wr_data   (wr_data),
        .o_tb_start  (tb_start),
        .o_tb_bank   (tb_bank)
    );

    survivor_memory u_surv (
        .sys_clk    (sys_clk),
        .i_rst_n    (i_rst_n),
        .i_wr_req   (wr_req),
        .i_wr_addr  (wr_addr),
        .i_wr_data  (wr_data),
        .o_wr_grant (wr_grant),
        .i_rd_req   (rd_req),
        .i_rd_addr  (rd_addr),
        .o_rd_grant (rd_grant),
        .o_rd_data  (rd_data)
    );

    traceback_unit u_tb (
        .sys_clk    (sys_clk),
        .i_rst_n    (i_rst_n),
        .i_tb_start (tb_start),
        .i_tb_bank  (tb_bank),
        .i_rd_grant (rd_grant),
        .i_rd_data  (rd_data),
        .o_rd_req   (rd_req),
        .o_rd_addr  (rd_addr),
        .o_busy     (tb_busy),
        .o_dec_data (o_dec_data),
        .o_dec_done (o_dec_done)
    );

endmodule

// ==== src/endec_control.sv ====
module endec_control (
    input  logic                               sys_clk,
    input  logic                               i_rst_n,
    input  logic                               i_start,
    input  logic                               i_mode_sel,
    input  logic                               i_code_rate,
    input  logic [viterbi_pkg::FRAME_BITS-1:0] i_enc_frame,
    input  logic [viterbi_pkg::CODE_BITS-1:0]  i_dec_frame,
    input  logic                               i_tb_busy,
    input  logic                               i_acs_wr_grant,
    output logic                               o_ready,
    output logic                               o_enc_start,
    output logic                               o_enc_bit,
    output logic                               o_step,
    output logic [viterbi_pkg::MAX_RATE-1:0]   o_rx_sym,
    output logic                               o_frame_end,
    output logic                               o_bank
);
    import viterbi_pkg::*;

    logic                 enc_run_q;
    logic                 dec_run_q;
    logic                 fend_wait_q;
    logic                 rate_q;
    logic [STEP_BITS:0]   cnt_q;
    logic [CODE_BITS-1:0] frame_q;
    logic                 accept;
    logic                 last_write;
    logic                 fend_pend;

    assign accept      = i_start && o_ready;
    assign o_ready     = !(enc_run_q || dec_run_q || fend_wait_q);
    assign o_enc_bit   = frame_q[0];
    assign o_step      = dec_run_q && !cnt_q[0];    // Even cycles add, odd cycles write.
    assign o_rx_sym    = rate_q ? frame_q[MAX_RATE-1:0] : {1'b0, frame_q[MAX_RATE-2:0]};
    assign last_write  = dec_run_q && cnt_q == 2 * FRAME_BITS - 1 && i_acs_wr_grant;

    // A frame end waits here while the previous frame is still in traceback.
    assign fend_pend   = last_write || fend_wait_q;
    assign o_frame_end = fend_pend && !i_tb_busy;

    always_ff @(posedge sys_clk) begin
        if (!i_rst_n) begin
            enc_run_q   <= 1'b0;
            dec_run_q   <= 1'b0;
            fend_wait_q <= 1'b0;
            rate_q      <= 1'b0;
            cnt_q       <= '0;
            o_enc_start <= 1'b0;
            o_bank      <= 1'b0;
        end else begin
            o_enc_start <= accept && !i_mode_sel;
            cnt_q       <= accept ? '0 : cnt_q + 1'b1;
            fend_wait_q <= fend_pend && i_tb_busy;
            if (accept) begin
                rate_q    <= i_code_rate;
                enc_run_q <= !i_mode_sel;
                dec_run_q <= i_mode_sel;
            end
            if (enc_run_q && cnt_q == FRAME_BITS)   // Encoder takes its last bit now.
                enc_run_q <= 1'b0;
            if (last_write)
                dec_run_q <= 1'b0;
            if (o_frame_end)
                o_bank <= !o_bank;
        end
    end

    // The encoder consumes one bit per cycle from the second cycle after the start.
    always_ff @(posedge sys_clk) begin
        if (accept)
            frame_q <= i_mode_sel ? i_dec_frame
                                  : CODE_BITS'(i_enc_frame[FRAME_BITS-TAIL_BITS-1:0]);
        else if (enc_run_q && cnt_q != '0)
            frame_q <= frame_q >> 1;
        else if (o_step)
            frame_q <= frame_q >> (rate_q ? MAX_RATE : MAX_RATE - 1);
    end

endmodule

// ==== src/survivor_memory.sv ====
module survivor_memory (
    input  logic                                   sys_clk,
    input  logic                                   i_rst_n,
    input  logic                                   i_wr_req,
    input  logic [viterbi_pkg::SURV_ADDR_BITS-1:0] i_wr_addr,
    input  logic [viterbi_pkg::NUM_STATES-1:0]     i_wr_data,
    output logic                                   o_wr_grant,
    input  logic                                   i_rd_req,
    input  logic [viterbi_pkg::SURV_ADDR_BITS-1:0] i_rd_addr,
    output logic                                   o_rd_grant,
    output logic [viterbi_pkg::NUM_STATES-1:0]     o_rd_data
);
    import viterbi_pkg::*;

    logic [NUM_STATES-1:0] mem_q [SURV_DEPTH];

    // The writer has priority since add-compare-select cannot stall.
    assign o_wr_grant = i_wr_req;
    assign o_rd_grant = i_rd_req && !i_wr_req;  // The reader retries next cycle.

    always_ff @(posedge sys_clk) begin
        if (o_wr_grant)
            mem_q[i_wr_addr] <= i_wr_data;
    end

    always_ff @(posedge sys_clk) begin
        if (!i_rst_n)
            o_rd_data <= '0;
        else if (o_rd_grant)
            o_rd_data <= mem_q[i_rd_addr];
    end

endmodule

// ==== src/traceback_unit.sv ====
module traceback_unit (
    input  logic                                   sys_clk,
    input  logic                                   i_rst_n,
    input  logic                                   i_tb_start,
    input  logic                                   i_tb_bank,
    input  logic                                   i_rd_grant,
    input  logic [viterbi_pkg::NUM_STATES-1:0]     i_rd_data,
    output logic                                   o_rd_req,
    output logic [viterbi_pkg::SURV_ADDR_BITS-1:0] o_rd_addr,
    output logic                                   o_busy,
    output logic [viterbi_pkg::FRAME_BITS-1:0]     o_dec_data,
    output logic                                   o_dec_done
);
    import viterbi_pkg::*;

    logic                  bank_q;
    logic                  rd_act_q;
    logic                  rd_vld_q;
    logic [STEP_BITS-1:0]  rd_step_q;
    logic [STATE_BITS-1:0] state_q;
    logic [FRAME_BITS-1:0] bits_q;
    logic                  last;

    assign o_rd_req  = rd_act_q;
    assign o_rd_addr = {bank_q, rd_step_q};

    // Read addresses do not depend on the path, so reads run ahead of the data.
    assign last = rd_vld_q && !rd_act_q;

    always_ff @(posedge sys_clk) begin
        if (!i_rst_n) begin
            bank_q     <= 1'b0;
            rd_act_q   <= 1'b0;
            rd_vld_q   <= 1'b0;
            rd_step_q  <= '0;
            state_q    <= '0;
            o_busy     <= 1'b0;
            o_dec_done <= 1'b0;
            o_dec_data <= '0;
        end else begin
            o_dec_done <= 1'b0;
            rd_vld_q   <= i_rd_grant;
            if (i_tb_start) begin                   // The tail leaves the path in state 0.
                o_busy    <= 1'b1;
                rd_act_q  <= 1'b1;
                bank_q    <= i_tb_bank;
                rd_step_q <= STEP_BITS'(FRAME_BITS - 1);
                state_q   <= '0;
            end
            if (i_rd_grant) begin
                rd_step_q <= rd_step_q - 1'b1;
                if (rd_step_q == '0)
                    rd_act_q <= 1'b0;
            end
            if (rd_vld_q)
                state_q <= {state_q[STATE_BITS-2:0], i_rd_data[state_q]};
            if (last) begin
                o_busy     <= 1'b0;
                o_dec_done <= 1'b1;
                o_dec_data <= {bits_q[FRAME_BITS-2:0], state_q[STATE_BITS-1]};
            end
        end
    end

    // The newest state bit is the decoded bit, step 15 ends up at the MSB.
    always_ff @(posedge sys_clk) begin
        if (rd_vld_q)
            bits_q <= {bits_q[FRAME_BITS-2:0], state_q[STATE_BITS-1]};
    end

endmodule

// ==== src/viterbi_pkg.sv ====
package viterbi_pkg;

    // ##################################################
    // Trellis geometry.
    // ##################################################
    localparam int CONSTR_LEN = 4;
    localparam int STATE_BITS = CONSTR_LEN - 1;
    localparam int NUM_STATES = 1 << STATE_BITS;
    localparam int MAX_RATE   = 3;                  // Output bits per step at rate 1/3.

    // ##################################################
    // Frame and codeword.
    // ##################################################
    localparam int FRAME_BITS = 16;                 // Also the number of trellis steps.
    localparam int TAIL_BITS  = 3;
    localparam int STEP_BITS  = $clog2(FRAME_BITS);
    localparam int CODE_BITS  = MAX_RATE * FRAME_BITS;

    // Polynomial j sits at bits CONSTR_LEN*j and up, its MSB taps the input bit.
    localparam int POLY_BITS = CONSTR_LEN * MAX_RATE;

    // Expected symbols, one per state and branch, indexed by {state, decision}.
    localparam int EXP_BITS = 2 * NUM_STATES * MAX_RATE;

    // ##################################################
    // Decoder storage.
    // ##################################################
    localparam int METRIC_BITS = 6;
    localparam logic [METRIC_BITS-1:0] METRIC_MAX = '1;

    // Two banks of one frame each, the bank is the address MSB.
    localparam int SURV_DEPTH     = 2 * FRAME_BITS;
    localparam int SURV_ADDR_BITS = $clog2(SURV_DEPTH);

endpackage

// ==== testbench/endec_checker.sv ====
module endec_checker (
    input logic                                   sys_clk,
    input logic                                   i_rst_n,
    input logic                                   i_wr_req,
    input logic                                   i_rd_req,
    input logic [viterbi_pkg::SURV_ADDR_BITS-1:0] i_rd_addr,
    input logic                                   i_rd_grant
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // ##################################################
    // Traffic rules of the two survivor memory peers.
    // ##################################################

    // The ACS stage writes at most every other cycle.
    a_wr_spacing: assert property (@(posedge sys_clk) disable iff (!i_rst_n)
        i_wr_req |=> !i_wr_req)
        else begin
            $error("Two survivor writes were requested in consecutive cycles.");
            fail_count++;
        end

    a_rd_retry: assert property (@(posedge sys_clk) disable iff (!i_rst_n)
        i_rd_req && !i_rd_grant |=> i_rd_req && $stable(i_rd_addr))
        else begin
            $error("A stalled read was dropped or changed its address.");
            fail_count++;
        end

    // A read never stalls for more than one cycle.
    a_rd_stall_short: assert property (@(posedge sys_clk) disable iff (!i_rst_n)
        i_rd_req && !i_rd_grant |=> i_rd_grant)
        else begin
            $error("A read stayed without a grant for two cycles in a row.");
            fail_count++;
        end

endmodule

bind survivor_memory endec_checker u_chk (
    .sys_clk    (sys_clk),
    .i_rst_n    (i_rst_n),
    .i_wr_req   (i_wr_req),
    .i_rd_req   (i_rd_req),
    .i_rd_addr  (i_rd_addr),
    .i_rd_grant (o_rd_grant)
);

// ==== testbench/endec_tb.sv ====
module endec_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import viterbi_pkg::*;

    localparam int ENC_FRAMES = 12;
    localparam int RT_FRAMES  = 6;
    localparam int ERR_FRAMES = 8;
    localparam int OVL_FRAMES = 6;
    localparam int NUM_FRAMES = ENC_FRAMES + RT_FRAMES + ERR_FRAMES + OVL_FRAMES + 2;
    localparam int TIMEOUT_CYCLES = 120 * NUM_FRAMES;
    localparam logic [POLY_BITS-1:0] POLY_R2 = 12'h0fd;    // Generators 15 and 17 octal.
    localparam logic [POLY_BITS-1:0] POLY_R3 = 12'hfdb;    // Generators 13, 15 and 17 octal.

    logic                  sys_clk;
    logic                  i_rst_n;
    logic                  i_start;
    logic                  i_mode_sel;
    logic                  i_code_rate;
    logic [POLY_BITS-1:0]  i_gen_poly;
    logic [FRAME_BITS-1:0] i_enc_frame;
    logic [CODE_BITS-1:0]  i_dec_frame;
    logic                  o_ready;
    logic [CODE_BITS-1:0]  o_enc_data;
    logic                  o_enc_done;
    logic [FRAME_BITS-1:0] o_dec_data;
    logic                  o_dec_done;

    integer seed = 32'hb26e_fd71;
    int     errors = 0;
    int     checks = 0;
    logic [CODE_BITS-1:0]  enc_exp_q[$];
    string                 enc_name_q[$];
    logic [FRAME_BITS-1:0] dec_exp_q[$];
    string                 dec_name_q[$];

    endec i_dut (.*);

    initial begin
        sys_clk = 1'b0;
        forever #50 sys_clk = ~sys_clk;
    end

    // ##################################################
    // Reference models.
    // ##################################################
    function automatic logic tap(input logic [CONSTR_LEN-1:0] win,
                                 input logic [POLY_BITS-1:0] poly, input int j);
        return ^(win & poly[j*CONSTR_LEN +: CONSTR_LEN]);
    endfunction

    function automatic logic [CODE_BITS-1:0] ref_encode(input logic [FRAME_BITS-1:0] data,
            input logic rate, input logic [POLY_BITS-1:0] poly);
        logic [CODE_BITS-1:0]  cw;
        logic [STATE_BITS-1:0] st;
        int                    r;
        cw = '0;
        st = '0;
        r  = rate ? 3 : 2;
        for (int t = 0; t < FRAME_BITS; t++) begin
            for (int j = 0; j < r; j++)
                cw[t*r+j] = tap({data[t], st}, poly, j);
            st = {data[t], st[STATE_BITS-1:1]};     // Newest bit enters at the top.
        end
        return cw;
    endfunction

    function automatic logic [FRAME_BITS-1:0] ref_decode(input logic [CODE_BITS-1:0] cw,
            input logic rate, input logic [POLY_BITS-1:0] poly);
        int                    pm[NUM_STATES];
        int                    nxt[NUM_STATES];
        int                    cand[2];
        int                    r;
        logic [NUM_STATES-1:0] surv[FRAME_BITS];
        logic [CONSTR_LEN-1:0] win;
        logic [STATE_BITS-1:0] st;
        logic [FRAME_BITS-1:0] res;
        r = rate ? 3 : 2;
        for (int s = 0; s < NUM_STATES; s++)
            pm[s] = (s == 0) ? 0 : int'(METRIC_MAX);
        for (int t = 0; t < FRAME_BITS; t++) begin
            for (int s = 0; s < NUM_STATES; s++) begin
                for (int d = 0; d < 2; d++) begin
                    win     = {3'(s), 1'(d)};       // Predecessor is the low three bits.
                    cand[d] = pm[win[STATE_BITS-1:0]];
                    for (int j = 0; j < r; j++)
                        cand[d] += int'(cw[t*r+j] ^ tap(win, poly, j));
                    if (cand[d] > int'(METRIC_MAX))
                        cand[d] = int'(METRIC_MAX);
                end
                surv[t][s] = cand[1] < cand[0];
                nxt[s]     = surv[t][s] ? cand[1] : cand[0];
            end
            pm = nxt;
        end
        st = '0;
        for (int t = FRAME_BITS - 1; t >= 0; t--) begin
            res[t] = st[STATE_BITS-1];
            st     = {st[STATE_BITS-2:0], surv[t][st]};
        end
        return res;
    endfunction

    function automatic logic [FRAME_BITS-1:0] rand_data();
        return {{TAIL_BITS{1'b0}}, (FRAME_BITS - TAIL_BITS)'($random(seed))};
    endfunction

    // ##################################################
    // Stimulus and checking tasks.
    // ##################################################
    task automatic check_value(input string name, input logic [CODE_BITS-1:0] expected,
                               input logic [CODE_BITS-1:0] actual);
        checks++;
        if (expected !== actual) begin
            $display("Error in %s: expected %0h, actual %0h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic send_frame(input string name, input logic mode, input logic rate,
                              input logic [POLY_BITS-1:0] poly, input logic [CODE_BITS-1:0] frame,
                              input logic [CODE_BITS-1:0] expected);
        while (!o_ready)
            @(negedge sys_clk);
        i_mode_sel  = mode;
        i_code_rate = rate;                         // Rate and polynomials stay until the next frame.
        i_gen_poly  = poly;
        i_enc_frame = frame[FRAME_BITS-1:0];
        i_dec_frame = frame;
        i_start     = 1'b1;
        if (mode) begin
            dec_exp_q.push_back(expected[FRAME_BITS-1:0]);
            dec_name_q.push_back(name);
        end else begin
            enc_exp_q.push_back(expected);
            enc_name_q.push_back(name);
        end
        @(negedge sys_clk);
        i_start = 1'b0;
    endtask

    task automatic pulse_ignored_start();
        check_value("busy before ignored start", 1'b0, o_ready);
        i_enc_frame = ~i_enc_frame;
        i_dec_frame = ~i_dec_frame;
        i_start     = 1'b1;
        @(negedge sys_clk);
        i_start = 1'b0;
    endtask

    task automatic wait_results();
        while (enc_exp_q.size() != 0 || dec_exp_q.size() != 0)
            @(negedge sys_clk);
    endtask

    initial begin
        forever begin
            @(negedge sys_clk);
            if (o_enc_done) begin
                if (enc_exp_q.size() == 0) begin
                    $display("Encoder done pulse arrived with no frame pending");
                    errors++;
                end else
                    check_value(enc_name_q.pop_front(), enc_exp_q.pop_front(), o_enc_data);
            end
            if (o_dec_done) begin
                if (dec_exp_q.size() == 0) begin
                    $display("Decoder done pulse arrived with no frame pending");
                    errors++;
                end else
                    check_value(dec_name_q.pop_front(), dec_exp_q.pop_front(), o_dec_data);
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge sys_clk);
        $display("Timeout after %0d cycles with frames still outstanding", TIMEOUT_CYCLES);
        $display("Regression failed");
        $finish;
    end

    initial begin
        logic [FRAME_BITS-1:0] data;
        logic                  rate;
        logic [POLY_BITS-1:0]  poly;
        logic [CODE_BITS-1:0]  cw;
        int                    pos;
        int                    asrt_fails;
        i_rst_n     = 1'b0;
        i_start     = 1'b0;
        i_mode_sel  = 1'b0;
        i_code_rate = 1'b0;
        i_gen_poly  = POLY_R2;
        i_enc_frame = '0;
        i_dec_frame = '0;
        repeat (5) @(negedge sys_clk);
        i_rst_n = 1'b1;
        @(negedge sys_clk);
        check_value("reset ready", 1'b1, o_ready);
        check_value("reset enc done", 1'b0, o_enc_done);
        check_value("reset dec done", 1'b0, o_dec_done);
        check_value("reset enc data", '0, o_enc_data);
        check_value("reset dec data", '0, o_dec_data);

        for (int i = 0; i < ENC_FRAMES; i++) begin
            data = rand_data();
            rate = (i < 4) ? 1'b0 : (i < 8) ? 1'b1 : 1'($random(seed));
            poly = (i < 4) ? POLY_R2 : (i < 8) ? POLY_R3 : 12'($random(seed));
            send_frame("encode", 1'b0, rate, poly, CODE_BITS'(data), ref_encode(data, rate, poly));
        end
        for (int i = 0; i < RT_FRAMES; i++) begin
            data = rand_data();
            rate = 1'(i);
            poly = rate ? POLY_R3 : POLY_R2;
            send_frame("round trip", 1'b1, rate, poly, ref_encode(data, rate, poly), data);
        end
        // One flipped bit, the standard codes must correct it.
        for (int i = 0; i < ERR_FRAMES; i++) begin
            data = rand_data();
            rate = 1'(i);
            poly = (i < 4) ? (rate ? POLY_R3 : POLY_R2) : 12'($random(seed));
            cw   = ref_encode(data, rate, poly);
            pos  = $unsigned($random(seed)) % (rate ? 48 : 32);
            cw[pos] = ~cw[pos];
            if (i < 4)
                send_frame("single error", 1'b1, rate, poly, cw, data);
            else
                send_frame("random poly error", 1'b1, rate, poly, cw, ref_decode(cw, rate, poly));
        end
        wait_results();

        // Back to back frames overlap traceback with the next add-compare-select.
        for (int i = 0; i < OVL_FRAMES; i++) begin
            data = rand_data();
            rate = 1'(i / 2);
            poly = rate ? POLY_R3 : POLY_R2;
            send_frame("overlap", 1'b1, rate, poly, ref_encode(data, rate, poly), data);
        end
        wait_results();

        data = rand_data();
        send_frame("ignored start decode", 1'b1, 1'b1, POLY_R3,
                   ref_encode(data, 1'b1, POLY_R3), data);
        repeat (4) @(negedge sys_clk);
        pulse_ignored_start();
        wait_results();
        data = rand_data();
        send_frame("ignored start encode", 1'b0, 1'b0, POLY_R2, CODE_BITS'(data),
                   ref_encode(data, 1'b0, POLY_R2));
        repeat (4) @(negedge sys_clk);
        pulse_ignored_start();
        wait_results();
        repeat (50) @(negedge sys_clk);             // Room for any stray done pulse.

        asrt_fails = i_dut.u_surv.u_chk.fail_count;
        $display("Summary: %0d checks, %0d errors, %0d assertion failures",
                 checks, errors, asrt_fails);
        if (errors == 0 && asrt_fails == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule
